// File: Bender.yml
package:
  name: usb_mem

sources:
  - design/usb_mem_pkg.sv
  - design/stream_if.sv
  - design/stream_fifo.sv
  - design/cmd_decoder.sv
  - design/sram_engine.sv
  - design/resp_serializer.sv
  - design/usb_mem_top.sv
  - target: test
    files:
      - dv/usb_mem_tb.sv

// File: build.f
design/usb_mem_pkg.sv
design/stream_if.sv
design/stream_fifo.sv
design/cmd_decoder.sv
design/sram_engine.sv
design/resp_serializer.sv
design/usb_mem_top.sv
dv/usb_mem_tb.sv

// File: design/cmd_decoder.sv
`timescale 1ns/1ns
module cmd_decoder
  import usb_mem_pkg::*;
(
  input  logic  usb_clk,
  input  logic  ce_q,
  stream_if.snk byte_s,
  stream_if.src req_s
);

  typedef enum logic [1:0] {
    ST_HEADER,
    ST_WDATA,
    ST_RISSUE,
    ST_DROP
  } state_e;

  localparam logic [1:0] LAST_BYTE = 2'(WORD_BYTES - 1);

  state_e                   state_q;
  cmd_op_e                  op_q;
  logic [1:0]               idx_q;
  logic [MAX_ADDR_BITS-1:0] addr_q;
  logic [7:0]               count_q;
  logic                     pkt_done_q;
  logic                     req_valid_q;
  word_t                    word_q;
  mem_req_t                 req_q;
  logic                     req_free;
  logic                     byte_fire;
  byte_t                    din;

  // Request register is empty or drains this cycle
  assign req_free  = !req_valid_q || req_s.ready;
  assign byte_s.ready = (state_q != ST_RISSUE) && req_free;
  assign byte_fire = byte_s.valid && byte_s.ready;
  assign din       = byte_s.payload;

  assign req_s.valid   = req_valid_q;
  assign req_s.payload = req_q;
  // Word streams carry last inside the payload
  assign req_s.last    = 1'b0;

  always_ff @(posedge usb_clk or negedge ce_q) begin
    if (!ce_q) begin
      state_q     <= ST_HEADER;
      op_q        <= OP_WRITE;
      idx_q       <= '0;
      addr_q      <= '0;
      count_q     <= '0;
      pkt_done_q  <= 1'b0;
      req_valid_q <= 1'b0;
    end else begin
      if (req_s.ready) begin
        req_valid_q <= 1'b0;
      end

      case (state_q)
        ST_HEADER: begin
          if (byte_fire) begin
            idx_q <= idx_q + 1'b1;
            case (idx_q)
              2'd0: begin
                op_q <= cmd_op_e'(din);
                if (!byte_s.last && !(din inside {OP_WRITE, OP_READ})) begin
                  state_q <= ST_DROP;
                  idx_q   <= '0;
                end
              end
              2'd1: addr_q[7:0] <= din;
              2'd2: addr_q[15:8] <= din;
              default: begin
                count_q    <= din;
                pkt_done_q <= byte_s.last;
                if (op_q == OP_READ) begin
                  state_q <= ST_RISSUE;
                end else if (!byte_s.last) begin
                  state_q <= ST_WDATA;
                end
              end
            endcase
            // Packet ended inside the header
            if (byte_s.last && idx_q != LAST_BYTE) begin
              idx_q <= '0;
            end
          end
        end

        ST_WDATA: begin
          if (byte_fire) begin
            idx_q <= idx_q + 1'b1;
            if (idx_q == LAST_BYTE) begin
              req_valid_q <= 1'b1;
              addr_q      <= addr_q + 1'b1;
              count_q     <= count_q - 1'b1;
              if (count_q == '0) begin
                state_q <= byte_s.last ? ST_HEADER : ST_DROP;
              end else if (byte_s.last) begin
                state_q <= ST_HEADER;
              end
            end else if (byte_s.last) begin
              // Partial word is discarded
              state_q <= ST_HEADER;
              idx_q   <= '0;
            end
          end
        end

        ST_RISSUE: begin
          if (req_free) begin
            req_valid_q <= 1'b1;
            addr_q      <= addr_q + 1'b1;
            count_q     <= count_q - 1'b1;
            if (count_q == '0) begin
              state_q <= pkt_done_q ? ST_HEADER : ST_DROP;
            end
          end
        end

        default: begin
          if (byte_fire && byte_s.last) begin
            state_q <= ST_HEADER;
          end
        end
      endcase
    end
  end

  // Word assembly and request payload
  always_ff @(posedge usb_clk) begin
    if (state_q == ST_WDATA && byte_fire) begin
      word_q[8*idx_q +: 8] <= din;
      if (idx_q == LAST_BYTE) begin
        req_q <= '{write: 1'b1, addr: addr_q, data: {din, word_q[23:0]}, last: 1'b0};
      end
    end else if (state_q == ST_RISSUE && req_free) begin
      req_q <= '{write: 1'b0, addr: addr_q, data: '0, last: (count_q == '0)};
    end
  end

  // Requests only come from packets with a known opcode
  a_legal_op: assert property (@(posedge usb_clk) disable iff (!ce_q)
    req_s.valid |-> (op_q inside {OP_WRITE, OP_READ}) &&
                    (req_s.payload.write == (op_q == OP_WRITE)));

endmodule

// File: design/resp_serializer.sv
`timescale 1ns/1ns
module resp_serializer
  import usb_mem_pkg::*;
(
  input  logic  usb_clk,
  input  logic  ce_q,
  stream_if.snk word_s,
  output logic  m_valid_o,
  input  logic  m_ready_i,
  output logic  m_last_o,
  output byte_t m_data_o
);

  localparam logic [1:0] LAST_BYTE = 2'(WORD_BYTES - 1);

  word_t      word_q;
  logic       last_q;
  logic       full_q;
  logic [1:0] idx_q;
  logic       byte_fire;
  logic       word_fire;

  assign byte_fire = full_q && m_ready_i;
  // Next word loads as the final byte of the current one leaves
  assign word_s.ready = !full_q || (m_ready_i && idx_q == LAST_BYTE);
  assign word_fire    = word_s.valid && word_s.ready;

  assign m_valid_o = full_q;
  assign m_data_o  = word_q[7:0];
  assign m_last_o  = full_q && last_q && (idx_q == LAST_BYTE);

  // LSB first, shifted down a byte at a time
  always_ff @(posedge usb_clk) begin
    if (word_fire) begin
      word_q <= word_s.payload.data;
      last_q <= word_s.payload.last;
    end else if (byte_fire) begin
      word_q <= {8'h00, word_q[$bits(word_t)-1:8]};
    end
  end

  always_ff @(posedge usb_clk or negedge ce_q) begin
    if (!ce_q) begin
      full_q <= 1'b0;
      idx_q  <= '0;
    end else if (word_fire) begin
      full_q <= 1'b1;
      idx_q  <= '0;
    end else if (byte_fire) begin
      if (idx_q == LAST_BYTE) begin
        full_q <= 1'b0;
      end
      idx_q <= idx_q + 1'b1;
    end
  end

endmodule

// File: design/sram_engine.sv
`timescale 1ns/1ns
module sram_engine
  import usb_mem_pkg::*;
#(
  parameter int ADDR_BITS = 10
) (
  input  logic  usb_clk,
  input  logic  ce_q,
  stream_if.snk req_s,
  stream_if.src resp_s
);

  localparam int DEPTH = 2 ** ADDR_BITS;

  word_t                mem [DEPTH];
  logic [ADDR_BITS-1:0] idx;
  logic                 req_fire;
  logic                 resp_valid_q;
  mem_resp_t            resp_q;

  // Addresses wrap modulo the memory depth
  assign idx = req_s.payload.addr[ADDR_BITS-1:0];

  // One-deep response, so accept only when it is empty or draining
  assign req_s.ready = !resp_valid_q || resp_s.ready;
  assign req_fire    = req_s.valid && req_s.ready;

  assign resp_s.valid   = resp_valid_q;
  assign resp_s.payload = resp_q;
  assign resp_s.last    = 1'b0;

  always_ff @(posedge usb_clk) begin
    if (req_fire && req_s.payload.write) begin
      mem[idx] <= req_s.payload.data;
    end
  end

  always_ff @(posedge usb_clk) begin
    if (req_fire && !req_s.payload.write) begin
      resp_q.data <= mem[idx];
      resp_q.last <= req_s.payload.last;
    end
  end

  always_ff @(posedge usb_clk or negedge ce_q) begin
    if (!ce_q) begin
      resp_valid_q <= 1'b0;
    end else if (req_fire && !req_s.payload.write) begin
      resp_valid_q <= 1'b1;
    end else if (resp_s.ready) begin
      resp_valid_q <= 1'b0;
    end
  end

  // Stalled response stays put until taken
  a_resp_hold: assert property (@(posedge usb_clk) disable iff (!ce_q)
    resp_s.valid && !resp_s.ready |=> resp_s.valid && $stable(resp_s.payload));

endmodule

// File: design/stream_fifo.sv
`timescale 1ns/1ns
module stream_fifo #(
  parameter type payload_t  = logic [7:0],
  parameter int  DEPTH_BITS = 4
) (
  input  logic  usb_clk,
  input  logic  ce_q,
  stream_if.snk in_s,
  stream_if.src out_s
);

  localparam int DEPTH = 2 ** DEPTH_BITS;

  payload_t            mem_data [DEPTH];
  logic                mem_last [DEPTH];
  logic [DEPTH_BITS:0] wr_ptr_q;
  logic [DEPTH_BITS:0] rd_ptr_q;
  logic [DEPTH_BITS:0] level;
  logic                buf_empty;
  logic                buf_full;
  logic                push;
  logic                pop;
  logic                out_load;
  logic                buf_rd;
  logic                buf_wr;
  logic                bypass;
  logic                out_valid_q;
  logic                out_last_q;
  payload_t            out_data_q;

  assign level     = wr_ptr_q - rd_ptr_q;
  assign buf_empty = (wr_ptr_q == rd_ptr_q);
  assign buf_full  = (wr_ptr_q[DEPTH_BITS] != rd_ptr_q[DEPTH_BITS]) &&
                     (wr_ptr_q[DEPTH_BITS-1:0] == rd_ptr_q[DEPTH_BITS-1:0]);

  assign in_s.ready    = !buf_full;
  assign out_s.valid   = out_valid_q;
  assign out_s.last    = out_last_q;
  assign out_s.payload = out_data_q;

  assign push     = in_s.valid && in_s.ready;
  assign pop      = out_valid_q && out_s.ready;
  // Output register can take a beat this cycle
  assign out_load = !out_valid_q || pop;
  assign buf_rd   = out_load && !buf_empty;
  // Incoming beat goes straight to the output when the buffer is empty
  assign bypass   = out_load && buf_empty && push;
  assign buf_wr   = push && !bypass;

  always_ff @(posedge usb_clk or negedge ce_q) begin
    if (!ce_q) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      out_valid_q <= 1'b0;
    end else begin
      if (buf_wr) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (buf_rd) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (out_load) begin
        out_valid_q <= !buf_empty || push;
      end
    end
  end

  always_ff @(posedge usb_clk) begin
    if (buf_wr) begin
      mem_data[wr_ptr_q[DEPTH_BITS-1:0]] <= in_s.payload;
      mem_last[wr_ptr_q[DEPTH_BITS-1:0]] <= in_s.last;
    end
    if (buf_rd) begin
      out_data_q <= mem_data[rd_ptr_q[DEPTH_BITS-1:0]];
      out_last_q <= mem_last[rd_ptr_q[DEPTH_BITS-1:0]];
    end else if (bypass) begin
      out_data_q <= in_s.payload;
      out_last_q <= in_s.last;
    end
  end

  // Occupancy never goes past the buffer depth
  a_no_overflow: assert property (@(posedge usb_clk) disable iff (!ce_q)
    level <= DEPTH);

  // Beats wait in the buffer only behind a full output register
  a_out_first: assert property (@(posedge usb_clk) disable iff (!ce_q)
    !out_valid_q |-> buf_empty);

endmodule

// File: design/stream_if.sv
`timescale 1ns/1ns
interface stream_if #(
  parameter type payload_t = logic [7:0]
);

  logic     valid;
  logic     ready;
  logic     last;
  payload_t payload;

  // Producer side
  modport src (
    output valid,
    output last,
    output payload,
    input  ready
  );

  // Consumer side
  modport snk (
    input  valid,
    input  last,
    input  payload,
    output ready
  );

endinterface

// File: design/usb_mem_pkg.sv
package usb_mem_pkg;

  // Stream and memory data types
  typedef logic [7:0] byte_t;
  typedef logic [31:0] word_t;

  localparam int WORD_BYTES = $bits(word_t) / $bits(byte_t);

  // Address field width in the packet header
  localparam int MAX_ADDR_BITS = 16;

  // Opcode in byte 0 of every packet header
  typedef enum logic [7:0] {
    OP_WRITE = 8'h01,
    OP_READ  = 8'h02
  } cmd_op_e;

  // Request from the command decoder to the memory engine
  typedef struct packed {
    logic                     write;
    logic [MAX_ADDR_BITS-1:0] addr;
    word_t                    data;
    // Final request of a read command
    logic                     last;
  } mem_req_t;

  // Read response word
  typedef struct packed {
    word_t data;
    logic  last;
  } mem_resp_t;

endpackage

// File: design/usb_mem_top.sv
`timescale 1ns/1ns
module usb_mem_top
  import usb_mem_pkg::*;
#(
  parameter int ADDR_BITS       = 10,
  parameter int FIFO_DEPTH_BITS = 4
) (
  input  logic       usb_clk,
  input  logic       ce_q,

  // Bulk OUT byte stream
  input  logic       s_valid_i,
  output logic       s_ready_o,
  input  logic       s_last_i,
  input  logic [7:0] s_data_i,

  // Bulk IN byte stream
  output logic       m_valid_o,
  input  logic       m_ready_i,
  output logic       m_last_o,
  output logic [7:0] m_data_o
);

  stream_if #(.payload_t(byte_t))     byte_in ();
  stream_if #(.payload_t(byte_t))     byte_q ();
  stream_if #(.payload_t(mem_req_t))  req ();
  stream_if #(.payload_t(mem_resp_t)) resp ();
  stream_if #(.payload_t(mem_resp_t)) resp_q ();

  assign byte_in.valid   = s_valid_i;
  assign byte_in.last    = s_last_i;
  assign byte_in.payload = s_data_i;
  assign s_ready_o       = byte_in.ready;

  stream_fifo #(
    .payload_t (byte_t),
    .DEPTH_BITS(FIFO_DEPTH_BITS)
  ) u_out_fifo (
    .usb_clk(usb_clk),
    .ce_q   (ce_q),
    .in_s   (byte_in),
    .out_s  (byte_q)
  );

  cmd_decoder u_cmd_decoder (
    .usb_clk(usb_clk),
    .ce_q   (ce_q),
    .byte_s (byte_q),
    .req_s  (req)
  );

  sram_engine #(
    .ADDR_BITS(ADDR_BITS)
  ) u_sram_engine (
    .usb_clk(usb_clk),
    .ce_q   (ce_q),
    .req_s  (req),
    .resp_s (resp)
  );

  // Absorbs read words while the IN side is stalled
  stream_fifo #(
    .payload_t (mem_resp_t),
    .DEPTH_BITS(FIFO_DEPTH_BITS)
  ) u_resp_fifo (
    .usb_clk(usb_clk),
    .ce_q   (ce_q),
    .in_s   (resp),
    .out_s  (resp_q)
  );

  resp_serializer u_resp_serializer (
    .usb_clk  (usb_clk),
    .ce_q     (ce_q),
    .word_s   (resp_q),
    .m_valid_o(m_valid_o),
    .m_ready_i(m_ready_i),
    .m_last_o (m_last_o),
    .m_data_o (m_data_o)
  );

endmodule

// File: dv/usb_mem_tb.sv
`timescale 1ns/1ns
module usb_mem_tb
  import usb_mem_pkg::*;
;

  localparam int ADDR_BITS       = 10;
  localparam int FIFO_DEPTH_BITS = 4;
  localparam int DEPTH           = 2 ** ADDR_BITS;

  logic       usb_clk;
  logic       ce_q;
  logic       s_valid_i;
  logic       s_ready_o;
  logic       s_last_i;
  logic [7:0] s_data_i;
  logic       m_valid_o;
  logic       m_ready_i;
  logic       m_last_o;
  logic [7:0] m_data_o;

  // Reference memory and expected IN bytes as {last, data}
  word_t      ref_mem [DEPTH];
  logic [8:0] exp_q [$];
  logic       exp_avail;
  logic       exp_last;
  byte_t      exp_data;
  logic       beat_seen;
  logic       saw_stall;
  int         ready_pct;
  int         budget_bytes;

  usb_mem_top #(
    .ADDR_BITS      (ADDR_BITS),
    .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)
  ) i_usb_mem_top (
    .usb_clk  (usb_clk),
    .ce_q     (ce_q),
    .s_valid_i(s_valid_i),
    .s_ready_o(s_ready_o),
    .s_last_i (s_last_i),
    .s_data_i (s_data_i),
    .m_valid_o(m_valid_o),
    .m_ready_i(m_ready_i),
    .m_last_o (m_last_o),
    .m_data_o (m_data_o)
  );

  initial begin
    usb_clk = 1'b0;
    forever #2 usb_clk = ~usb_clk;
  end

  task automatic stop_with_fail(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic load_head();
    exp_avail = (exp_q.size() != 0);
    if (exp_avail) begin
      {exp_last, exp_data} = exp_q[0];
    end
  endtask

  function automatic void add_header(ref byte_t pkt[$], input byte_t op, input int addr,
                                     input int nwords);
    pkt.push_back(op);
    pkt.push_back(addr[7:0]);
    pkt.push_back(addr[15:8]);
    pkt.push_back(8'(nwords - 1));
  endfunction

  // Each byte is held until s_ready_o is high at a rising edge
  task automatic drive_packet(input byte_t pkt[$]);
    bit took;
    budget_bytes += pkt.size();
    foreach (pkt[i]) begin
      s_valid_i = 1'b1;
      s_data_i  = pkt[i];
      s_last_i  = (i == pkt.size() - 1);
      took      = 1'b0;
      while (!took) begin
        @(negedge usb_clk);
        took = s_ready_o;
        @(posedge usb_clk);
        #1;
      end
    end
    s_valid_i = 1'b0;
    s_last_i  = 1'b0;
  endtask

  // A data_bytes value below nwords*4 cuts the packet short
  // Extra bytes go past the expected length
  task automatic write_packet(input int addr, input int nwords, input int data_bytes,
                              input int extra);
    byte_t pkt[$];
    word_t data;
    add_header(pkt, OP_WRITE, addr, nwords);
    for (int w = 0; w < nwords; w++) begin
      data = $urandom;
      if ((w + 1) * WORD_BYTES <= data_bytes) begin
        ref_mem[(addr + w) & (DEPTH - 1)] = data;
      end
      for (int b = 0; b < WORD_BYTES; b++) begin
        pkt.push_back(data[8*b +: 8]);
      end
    end
    while (pkt.size() > 4 + data_bytes) begin
      void'(pkt.pop_back());
    end
    repeat (extra) pkt.push_back(8'($urandom));
    drive_packet(pkt);
  endtask

  task automatic read_packet(input int addr, input int nwords, input int extra);
    byte_t pkt[$];
    word_t data;
    add_header(pkt, OP_READ, addr, nwords);
    repeat (extra) pkt.push_back(8'($urandom));
    for (int w = 0; w < nwords; w++) begin
      data = ref_mem[(addr + w) & (DEPTH - 1)];
      for (int b = 0; b < WORD_BYTES; b++) begin
        exp_q.push_back({(w == nwords - 1) && (b == WORD_BYTES - 1), data[8*b +: 8]});
      end
    end
    budget_bytes += nwords * WORD_BYTES;
    load_head();
    drive_packet(pkt);
  endtask

  task automatic junk_packet(input int len);
    byte_t pkt[$];
    byte_t op;
    do begin
      op = 8'($urandom);
    end while (op == OP_WRITE || op == OP_READ);
    pkt.push_back(op);
    repeat (len - 1) pkt.push_back(8'($urandom));
    drive_packet(pkt);
  endtask

  task automatic drive_ready();
    forever begin
      @(posedge usb_clk);
      #1;
      m_ready_i = ($urandom_range(99) < ready_pct);
    end
  endtask

  always @(negedge usb_clk) begin
    beat_seen <= ce_q && m_valid_o && m_ready_i;
    if (ce_q && s_valid_i && !s_ready_o) begin
      saw_stall <= 1'b1;
    end
  end

  always @(posedge usb_clk) begin
    if (beat_seen) begin
      if (exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
      load_head();
    end
  end

  a_reset_idle: assert property (@(posedge usb_clk) $rose(ce_q) |-> !m_valid_o && s_ready_o)
    else stop_with_fail("m_valid_o high or s_ready_o low right after reset");

  a_in_expected: assert property (@(posedge usb_clk) disable iff (!ce_q)
    m_valid_o && m_ready_i |-> exp_avail)
    else stop_with_fail("IN byte accepted while no byte was expected");

  a_in_data: assert property (@(posedge usb_clk) disable iff (!ce_q)
    m_valid_o && m_ready_i && exp_avail |-> m_data_o == exp_data)
    else stop_with_fail($sformatf("mismatch at %0t ns: m_data_o got 0x%02h, expected 0x%02h",
                                  $time, $sampled(m_data_o), $sampled(exp_data)));

  a_in_last: assert property (@(posedge usb_clk) disable iff (!ce_q)
    m_valid_o && m_ready_i && exp_avail |-> m_last_o == exp_last)
    else stop_with_fail($sformatf("mismatch at %0t ns: m_last_o got %0b, expected %0b",
                                  $time, $sampled(m_last_o), $sampled(exp_last)));

  a_in_hold: assert property (@(posedge usb_clk) disable iff (!ce_q)
    m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_data_o) && $stable(m_last_o))
    else stop_with_fail("IN byte dropped or changed while m_ready_i was low");

  // Limit grows with every byte queued in either direction
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= 40 * budget_bytes + 400) begin
      @(posedge usb_clk);
      cycles++;
    end
    stop_with_fail($sformatf("timeout after %0d cycles with %0d IN bytes outstanding",
                             cycles, exp_q.size()));
  end

  initial begin
    int addr;
    int n;
    void'($urandom(30695));
    ce_q         = 1'b0;
    s_valid_i    = 1'b0;
    s_last_i     = 1'b0;
    s_data_i     = '0;
    m_ready_i    = 1'b0;
    beat_seen    = 1'b0;
    saw_stall    = 1'b0;
    ready_pct    = 100;
    budget_bytes = 0;
    load_head();
    repeat (10) @(posedge usb_clk);
    #1;
    ce_q = 1'b1;
    fork
      drive_ready();
    join_none
    repeat (2) @(posedge usb_clk);
    #1;

    // Fill the whole memory so every later read is defined
    for (int base = 0; base < DEPTH; base += 256) begin
      write_packet(base, 256, 1024, 0);
    end

    ready_pct = 70;
    repeat (6) begin
      addr = $urandom_range(DEPTH - 1);
      n    = $urandom_range(24, 1);
      write_packet(addr, n, n * WORD_BYTES, 0);
      read_packet(addr, n, 0);
    end

    // Wrap at the top of memory and through the high header address bits
    write_packet(DEPTH - 3, 8, 32, 0);
    read_packet(DEPTH - 5, 12, 0);
    read_packet(16'hFFFE, 6, 0);

    addr = $urandom_range(DEPTH - 1);
    junk_packet(9);
    write_packet(addr, 4, 16, 5);
    read_packet($urandom_range(DEPTH - 1), 3, 6);
    read_packet(addr - 1, 6, 0);

    // Three full words and one stray byte
    addr = $urandom_range(DEPTH - 1);
    write_packet(addr, 8, 13, 0);
    read_packet(addr, 8, 0);

    ready_pct = 40;
    repeat (4) begin
      addr = $urandom_range(DEPTH - 1);
      n    = $urandom_range(40, 1);
      write_packet(addr, n, n * WORD_BYTES, 0);
      read_packet(addr - 2, n + 4, 0);
    end

    // Only the long read packets below may set the stall flag
    ready_pct = 50;
    saw_stall = 1'b0;
    repeat (6) read_packet($urandom_range(DEPTH - 1), 256, 0);

    while (exp_q.size() != 0) begin
      @(posedge usb_clk);
    end
    repeat (20) @(posedge usb_clk);
    if (!saw_stall) begin
      stop_with_fail("s_ready_o never went low during the long read packets");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule
